//--- Bender.yml
package:
  name: mips_core

sources:
  - files:
      - rtl/mips_pkg.sv
      - rtl/mips_alu.sv
      - rtl/mips_decoder.sv
      - rtl/mips_regfile.sv
      - rtl/mips_hazard_unit.sv
      - rtl/mips_core.sv
  - target: test
    files:
      - verification/tb_mips_core.sv

//--- project.f
rtl/mips_pkg.sv
rtl/mips_alu.sv
rtl/mips_decoder.sv
rtl/mips_regfile.sv
rtl/mips_hazard_unit.sv
rtl/mips_core.sv
verification/tb_mips_core.sv

//--- rtl/mips_alu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  word_t   a,
    input  word_t   b,
    input  alu_op_e op,
    output word_t   y
);

    logic lt;

    // Signed compare for slt
    assign lt = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_SLT: y = {{(XLEN-1){1'b0}}, lt};
            ALU_LUI: y = {b[15:0], 16'h0000};
            default: y = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; #(
    parameter word_t RESET_PC = 32'h0000_3000
) (
    input  logic       clk,
    input  logic       arst_n,
    output word_t      i_inst_addr,
    input  word_t      i_inst_rdata,
    output word_t      m_data_addr,
    input  word_t      m_data_rdata,
    output word_t      m_data_wdata,
    output logic [3:0] m_data_byteen,
    output logic       w_grf_we,
    output reg_addr_t  w_grf_addr,
    output word_t      w_grf_wdata,
    output word_t      w_inst_addr
);

    word_t     f_pc;
    word_t     f_npc;
    word_t     fd_pc;
    word_t     fd_instr;
    reg_addr_t d_rs;
    reg_addr_t d_rt;
    ctrl_t     d_ctrl;
    word_t     d_rf1;
    word_t     d_rf2;
    word_t     d_v1;
    word_t     d_v2;
    word_t     d_imm32;
    word_t     d_pc4;
    logic      d_taken;
    de_reg_t   de;
    ctrl_t     e_ctrl;
    word_t     e_a;
    word_t     e_b_fwd;
    word_t     e_alu;
    word_t     e_pc8;
    em_reg_t   em;
    ctrl_t     m_ctrl;
    word_t     m_result;
    mw_reg_t   mw;
    word_t     w_wd;
    logic      stall;
    fwd_sel_e  fwd_d_rs;
    fwd_sel_e  fwd_d_rt;
    fwd_sel_e  fwd_e_a;
    fwd_sel_e  fwd_e_b;
    fwd_sel_e  fwd_m_wd;

    function automatic word_t fwd_pick(input fwd_sel_e sel, input word_t own,
                                       input word_t from_e, input word_t from_m,
                                       input word_t from_w);
        case (sel)
            FROM_E:  return from_e;
            FROM_M:  return from_m;
            FROM_W:  return from_w;
            default: return own;
        endcase
    endfunction

    // --------------------
    // Fetch
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            f_pc     <= RESET_PC;
            fd_pc    <= '0;
            fd_instr <= '0;
        end else if (!stall) begin
            f_pc     <= f_npc;
            fd_pc    <= f_pc;
            fd_instr <= i_inst_rdata;
        end
    end

    assign i_inst_addr = f_pc;

    // --------------------
    // Decode
    assign d_rs = fd_instr[25:21];
    assign d_rt = fd_instr[20:16];

    mips_decoder u_decoder (.instr(fd_instr), .ctrl(d_ctrl));

    mips_regfile u_regfile (
        .clk    (clk),
        .arst_n (arst_n),
        .ra1    (d_rs),
        .ra2    (d_rt),
        .we     (mw.ctrl.reg_we),
        .wa     (mw.ctrl.dest),
        .wd     (w_wd),
        .rd1    (d_rf1),
        .rd2    (d_rf2)
    );

    assign d_v1    = fwd_pick(fwd_d_rs, d_rf1, e_pc8, m_result, w_wd);
    assign d_v2    = fwd_pick(fwd_d_rt, d_rf2, e_pc8, m_result, w_wd);
    assign d_imm32 = d_ctrl.sign_ext ? {{16{fd_instr[15]}}, fd_instr[15:0]}
                                     : {16'h0000, fd_instr[15:0]};
    assign d_pc4   = fd_pc + 32'd4;

    // Branch resolves here and the delay slot is already in fetch
    always_comb begin
        case (d_ctrl.cmp_op)
            CMP_EQ:  d_taken = (d_v1 == d_v2);
            CMP_NE:  d_taken = (d_v1 != d_v2);
            default: d_taken = 1'b0;
        endcase
        case (d_ctrl.npc_sel)
            NPC_BRANCH: f_npc = d_taken ? d_pc4 + {d_imm32[29:0], 2'b00} : f_pc + 32'd4;
            NPC_JUMP:   f_npc = {d_pc4[31:28], fd_instr[25:0], 2'b00};
            NPC_JREG:   f_npc = d_v1;
            default:    f_npc = f_pc + 32'd4;
        endcase
    end

    // --------------------
    // Execute
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            de <= '0;
        end else if (stall) begin
            de <= '0;
        end else begin
            de <= '{pc: fd_pc, instr: fd_instr, v1: d_v1, v2: d_v2, imm32: d_imm32,
                    ctrl: d_ctrl};
        end
    end

    assign e_pc8   = de.pc + 32'd8;
    assign e_a     = fwd_pick(fwd_e_a, de.v1, de.v1, m_result, w_wd);
    assign e_b_fwd = fwd_pick(fwd_e_b, de.v2, de.v2, m_result, w_wd);

    mips_alu u_alu (
        .a  (e_a),
        .b  (de.ctrl.b_is_imm ? de.imm32 : e_b_fwd),
        .op (de.ctrl.alu_op),
        .y  (e_alu)
    );

    always_comb begin
        e_ctrl       = de.ctrl;
        e_ctrl.t_new = tick_dec(de.ctrl.t_new);
    end

    // --------------------
    // Memory
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            em <= '0;
        end else begin
            em <= '{pc: de.pc, instr: de.instr, alu: e_alu, wdata: e_b_fwd, ctrl: e_ctrl};
        end
    end

    assign m_result      = (em.ctrl.wb_src == WB_PC8) ? em.pc + 32'd8 : em.alu;
    assign m_data_addr   = em.alu;
    assign m_data_wdata  = fwd_pick(fwd_m_wd, em.wdata, em.wdata, em.wdata, w_wd);
    // Whole-word stores only
    assign m_data_byteen = {4{em.ctrl.mem_we}};

    always_comb begin
        m_ctrl       = em.ctrl;
        m_ctrl.t_new = tick_dec(em.ctrl.t_new);
    end

    // --------------------
    // Write-back
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mw <= '0;
        end else begin
            mw <= '{pc: em.pc, alu: em.alu, rdata: m_data_rdata, ctrl: m_ctrl};
        end
    end

    always_comb begin
        case (mw.ctrl.wb_src)
            WB_MEM:  w_wd = mw.rdata;
            WB_PC8:  w_wd = mw.pc + 32'd8;
            default: w_wd = mw.alu;
        endcase
    end

    assign w_grf_we    = mw.ctrl.reg_we;
    assign w_grf_addr  = mw.ctrl.dest;
    assign w_grf_wdata = w_wd;
    assign w_inst_addr = mw.pc;

    mips_hazard_unit u_hazard (
        .d_rs       (d_rs),
        .d_rt       (d_rt),
        .d_t_use_rs (d_ctrl.t_use_rs),
        .d_t_use_rt (d_ctrl.t_use_rt),
        .e_rs       (de.instr[25:21]),
        .e_rt       (de.instr[20:16]),
        .m_rt       (em.instr[20:16]),
        .e_dest     (de.ctrl.dest),
        .m_dest     (em.ctrl.dest),
        .w_dest     (mw.ctrl.dest),
        .e_we       (de.ctrl.reg_we),
        .m_we       (em.ctrl.reg_we),
        .w_we       (mw.ctrl.reg_we),
        .e_t_new    (de.ctrl.t_new),
        .m_t_new    (em.ctrl.t_new),
        .stall      (stall),
        .fwd_d_rs   (fwd_d_rs),
        .fwd_d_rt   (fwd_d_rt),
        .fwd_e_a    (fwd_e_a),
        .fwd_e_b    (fwd_e_b),
        .fwd_m_wd   (fwd_m_wd)
    );

    a_pc_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        i_inst_addr[1:0] == 2'b00)
        else $error("fetch address %h is not word aligned", i_inst_addr);

endmodule

`default_nettype wire

//--- rtl/mips_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module mips_decoder import mips_pkg::*; (
    input  word_t instr,
    output ctrl_t ctrl
);

    opcode_e   opcode;
    funct_e    funct;
    reg_addr_t rt;
    reg_addr_t rd;

    assign opcode = opcode_e'(instr[31:26]);
    assign funct  = funct_e'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    always_comb begin
        // No-op unless an encoding below matches
        ctrl          = '0;
        ctrl.t_use_rs = T_USE_NONE;
        ctrl.t_use_rt = T_USE_NONE;

        case (opcode)
            OP_SPECIAL: begin
                ctrl.reg_we   = 1'b1;
                ctrl.dest     = rd;
                ctrl.t_use_rs = 2'd1;
                ctrl.t_use_rt = 2'd1;
                case (funct)
                    FN_ADDU: ctrl.alu_op = ALU_ADD;
                    FN_SUBU: ctrl.alu_op = ALU_SUB;
                    FN_AND:  ctrl.alu_op = ALU_AND;
                    FN_OR:   ctrl.alu_op = ALU_OR;
                    FN_SLT:  ctrl.alu_op = ALU_SLT;
                    FN_JR: begin
                        ctrl.reg_we   = 1'b0;
                        ctrl.dest     = '0;
                        ctrl.npc_sel  = NPC_JREG;
                        ctrl.t_use_rs = 2'd0;
                        ctrl.t_use_rt = T_USE_NONE;
                    end
                    default: begin
                        ctrl.reg_we   = 1'b0;
                        ctrl.dest     = '0;
                        ctrl.t_use_rs = T_USE_NONE;
                        ctrl.t_use_rt = T_USE_NONE;
                    end
                endcase
            end
            OP_ADDIU, OP_ORI, OP_LUI, OP_LW: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.sign_ext = (opcode != OP_ORI);
                ctrl.reg_we   = 1'b1;
                ctrl.dest     = rt;
                ctrl.t_use_rs = (opcode == OP_LUI) ? T_USE_NONE : 2'd1;
                ctrl.alu_op   = (opcode == OP_ORI) ? ALU_OR :
                                (opcode == OP_LUI) ? ALU_LUI : ALU_ADD;
                ctrl.wb_src   = (opcode == OP_LW) ? WB_MEM : WB_ALU;
            end
            OP_SW: begin
                ctrl.b_is_imm = 1'b1;
                ctrl.sign_ext = 1'b1;
                ctrl.mem_we   = 1'b1;
                ctrl.t_use_rs = 2'd1;
                // Store data is needed only in memory stage
                ctrl.t_use_rt = 2'd2;
            end
            OP_BEQ, OP_BNE: begin
                // Branch offsets reach backwards too
                ctrl.sign_ext = 1'b1;
                ctrl.npc_sel  = NPC_BRANCH;
                ctrl.cmp_op   = (opcode == OP_BEQ) ? CMP_EQ : CMP_NE;
                ctrl.t_use_rs = 2'd0;
                ctrl.t_use_rt = 2'd0;
            end
            OP_J, OP_JAL: begin
                ctrl.npc_sel = NPC_JUMP;
                ctrl.reg_we  = (opcode == OP_JAL);
                ctrl.dest    = (opcode == OP_JAL) ? reg_addr_t'(31) : reg_addr_t'(0);
                ctrl.wb_src  = WB_PC8;
            end
            default: ;
        endcase

        // Cycles from execute until the result exists
        case (ctrl.wb_src)
            WB_MEM:  ctrl.t_new = 2'd2;
            WB_ALU:  ctrl.t_new = 2'd1;
            default: ctrl.t_new = 2'd0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/mips_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module mips_hazard_unit import mips_pkg::*; (
    input  reg_addr_t d_rs,
    input  reg_addr_t d_rt,
    input  tick_t     d_t_use_rs,
    input  tick_t     d_t_use_rt,
    input  reg_addr_t e_rs,
    input  reg_addr_t e_rt,
    input  reg_addr_t m_rt,
    input  reg_addr_t e_dest,
    input  reg_addr_t m_dest,
    input  reg_addr_t w_dest,
    input  logic      e_we,
    input  logic      m_we,
    input  logic      w_we,
    input  tick_t     e_t_new,
    input  tick_t     m_t_new,
    output logic      stall,
    output fwd_sel_e  fwd_d_rs,
    output fwd_sel_e  fwd_d_rt,
    output fwd_sel_e  fwd_e_a,
    output fwd_sel_e  fwd_e_b,
    output fwd_sel_e  fwd_m_wd
);

    logic sel_e_any;
    logic sel_m_any;
    logic sel_w_any;

    // Older writer of src will not be ready in time
    function automatic logic must_wait(input reg_addr_t src, input tick_t t_use);
        return (src != '0) &&
               ((e_we && e_dest == src && e_t_new > t_use) ||
                (m_we && m_dest == src && m_t_new > t_use));
    endfunction

    // Youngest writer ahead of the consumer wins
    function automatic fwd_sel_e pick(input reg_addr_t src, input logic see_e,
                                      input logic see_m);
        if (src == '0) begin
            return FWD_NONE;
        end
        if (see_e && e_we && e_dest == src) begin
            return (e_t_new == '0) ? FROM_E : FWD_NONE;
        end
        if (see_m && m_we && m_dest == src) begin
            return (m_t_new == '0) ? FROM_M : FWD_NONE;
        end
        return (w_we && w_dest == src) ? FROM_W : FWD_NONE;
    endfunction

    always_comb begin
        stall    = must_wait(d_rs, d_t_use_rs) || must_wait(d_rt, d_t_use_rt);
        fwd_d_rs = pick(d_rs, 1'b1, 1'b1);
        fwd_d_rt = pick(d_rt, 1'b1, 1'b1);
        fwd_e_a  = pick(e_rs, 1'b0, 1'b1);
        fwd_e_b  = pick(e_rt, 1'b0, 1'b1);
        fwd_m_wd = pick(m_rt, 1'b0, 1'b0);
    end

    assign sel_e_any = (fwd_d_rs == FROM_E) || (fwd_d_rt == FROM_E);
    assign sel_m_any = (fwd_d_rs == FROM_M) || (fwd_d_rt == FROM_M) ||
                       (fwd_e_a == FROM_M) || (fwd_e_b == FROM_M);
    assign sel_w_any = (fwd_d_rs == FROM_W) || (fwd_d_rt == FROM_W) ||
                       (fwd_e_a == FROM_W) || (fwd_e_b == FROM_W) || (fwd_m_wd == FROM_W);

    always_comb begin
        a_no_fwd_r0: assert final (!(sel_e_any && e_dest == '0) &&
                                   !(sel_m_any && m_dest == '0) &&
                                   !(sel_w_any && w_dest == '0))
            else $error("forward select names a write to register 0");
    end

endmodule

`default_nettype wire

//--- rtl/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // --------------------
    // Widths
    localparam int XLEN = 32;
    localparam int RLEN = 5;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [RLEN-1:0] reg_addr_t;
    typedef logic [1:0]      tick_t;

    // T_use of a register the instruction never reads
    localparam tick_t T_USE_NONE = 2'd3;

    // --------------------
    // Instruction encodings
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        FN_JR   = 6'h08,
        FN_ADDU = 6'h21,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_SLT  = 6'h2a
    } funct_e;

    // --------------------
    // Control encodings
    typedef enum logic [2:0] {ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_SLT, ALU_LUI} alu_op_e;
    typedef enum logic [1:0] {NPC_SEQ, NPC_BRANCH, NPC_JUMP, NPC_JREG} npc_sel_e;
    typedef enum logic [1:0] {CMP_NONE, CMP_EQ, CMP_NE} cmp_op_e;
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_PC8} wb_src_e;
    typedef enum logic [1:0] {FWD_NONE, FROM_E, FROM_M, FROM_W} fwd_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      b_is_imm;
        logic      sign_ext;
        npc_sel_e  npc_sel;
        cmp_op_e   cmp_op;
        wb_src_e   wb_src;
        logic      reg_we;
        logic      mem_we;
        reg_addr_t dest;
        tick_t     t_use_rs;
        tick_t     t_use_rt;
        tick_t     t_new;
    } ctrl_t;

    // --------------------
    // Pipeline registers
    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t v1;
        word_t v2;
        word_t imm32;
        ctrl_t ctrl;
    } de_reg_t;

    typedef struct packed {
        word_t pc;
        word_t instr;
        word_t alu;
        word_t wdata;
        ctrl_t ctrl;
    } em_reg_t;

    typedef struct packed {
        word_t pc;
        word_t alu;
        word_t rdata;
        ctrl_t ctrl;
    } mw_reg_t;

    // One stage closer to the result, saturating at zero
    function automatic tick_t tick_dec(input tick_t t);
        return (t == '0) ? '0 : t - 2'd1;
    endfunction

endpackage

`default_nettype wire

//--- rtl/mips_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic      clk,
    input  logic      arst_n,
    input  reg_addr_t ra1,
    input  reg_addr_t ra2,
    input  logic      we,
    input  reg_addr_t wa,
    input  word_t     wd,
    output word_t     rd1,
    output word_t     rd2
);

    // Entry 0 is cleared at reset and never written
    word_t regs [0:31];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // Same-cycle write is visible to decode
    assign rd1 = (we && wa != '0 && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (we && wa != '0 && wa == ra2) ? wd : regs[ra2];

    a_zero_reads: assert property (@(posedge clk) disable iff (!arst_n)
        ((ra1 != '0) || (rd1 == '0)) && ((ra2 != '0) || (rd2 == '0)))
        else $error("register 0 read back nonzero");

endmodule

`default_nettype wire

//--- verification/mips_core_patterns.txt
# P <byte address> <instruction word>, program in instruction memory
# T <pc> <register> <value>, expected register writes in program order (hex)
P 00003000 3C011234
P 00003004 34215678
P 00003008 2402FFFF
P 0000300c 00221821
P 00003010 00412023
P 00003014 00642824
P 00003018 00643025
P 0000301c 0041382A
P 00003020 0022402A
P 00003024 24490002
P 00003028 AC010010
P 0000302c AC040014
P 00003030 8C0A0010
P 00003034 014A5821
P 00003038 8C0C0014
P 0000303c AC0C0018
P 00003040 8C0D0018
P 00003044 240E0005
P 00003048 11C70003
P 0000304c 240F0001
P 00003050 24100002
P 00003054 160F0002
P 00003058 24110003
P 0000305c 24120099
P 00003060 11EF0002
P 00003064 24130004
P 00003068 24120098
P 0000306c 15EF0002
P 00003070 24140006
P 00003074 24150007
P 00003078 0C000C24
P 0000307c 24160008
P 00003080 24170009
P 00003084 08000C28
P 00003088 2418000A
P 0000308c 24120097
P 00003090 27F90000
P 00003094 03E00008
P 00003098 241A000B
P 0000309c 24120096
P 000030a0 00210021
P 000030a4 0000D821
P 000030a8 0001E025
# Expected write-back trace
T 00003000 01 12340000
T 00003004 01 12345678
T 00003008 02 ffffffff
T 0000300c 03 12345677
T 00003010 04 edcba987
T 00003014 05 00000007
T 00003018 06 fffffff7
T 0000301c 07 00000001
T 00003020 08 00000000
T 00003024 09 00000001
T 00003030 0a 12345678
T 00003034 0b 2468acf0
T 00003038 0c edcba987
T 00003040 0d edcba987
T 00003044 0e 00000005
T 0000304c 0f 00000001
T 00003050 10 00000002
T 00003058 11 00000003
T 00003064 13 00000004
T 00003070 14 00000006
T 00003074 15 00000007
T 00003078 1f 00003080
T 0000307c 16 00000008
T 00003090 19 00003080
T 00003098 1a 0000000b
T 00003080 17 00000009
T 00003088 18 0000000a
T 000030a4 1b 00000000
T 000030a8 1c 12345678

//--- verification/tb_mips_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

    localparam word_t       RESET_PC   = 32'h0000_3000;
    localparam int          IMEM_WORDS = 256;
    localparam int          DMEM_WORDS = 256;
    localparam int unsigned RAND_SEED  = 32'h091ed127;
    localparam string       PATTERN_FILE = "verification/mips_core_patterns.txt";

    logic       clk;
    logic       arst_n;
    word_t      i_inst_addr;
    word_t      i_inst_rdata;
    word_t      m_data_addr;
    word_t      m_data_rdata;
    word_t      m_data_wdata;
    logic [3:0] m_data_byteen;
    logic       w_grf_we;
    reg_addr_t  w_grf_addr;
    word_t      w_grf_wdata;
    word_t      w_inst_addr;

    word_t       imem [0:IMEM_WORDS-1];
    word_t       dmem [0:DMEM_WORDS-1];
    word_t       exp_pc [$];
    reg_addr_t   exp_reg [$];
    word_t       exp_val [$];
    int          prog_len;
    int          trace_len;
    int          trace_idx;
    int unsigned watchdog_cycles;

    mips_core #(.RESET_PC(RESET_PC)) UUT (
        .clk           (clk),
        .arst_n        (arst_n),
        .i_inst_addr   (i_inst_addr),
        .i_inst_rdata  (i_inst_rdata),
        .m_data_addr   (m_data_addr),
        .m_data_rdata  (m_data_rdata),
        .m_data_wdata  (m_data_wdata),
        .m_data_byteen (m_data_byteen),
        .w_grf_we      (w_grf_we),
        .w_grf_addr    (w_grf_addr),
        .w_grf_wdata   (w_grf_wdata),
        .w_inst_addr   (w_inst_addr)
    );

    // --------------------
    // Helpers
    task automatic abort_run();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Nop outside the loaded program
    function automatic word_t fetch_word(input word_t addr);
        word_t idx;
        idx = (addr - RESET_PC) >> 2;
        if (addr < RESET_PC || idx >= IMEM_WORDS) begin
            return '0;
        end
        return imem[idx];
    endfunction

    task automatic load_patterns();
        int        fd;
        int        n;
        string     line;
        word_t     a;
        word_t     w;
        reg_addr_t r;
        fd = $fopen(PATTERN_FILE, "r");
        if (fd == 0) begin
            $display("Error: cannot open %s", PATTERN_FILE);
            abort_run();
        end else begin
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line[0] == "P") begin
                    n = $sscanf(line, "P %h %h", a, w);
                    if (n != 2 || a < RESET_PC || ((a - RESET_PC) >> 2) >= IMEM_WORDS) begin
                        $display("Error: bad program line in pattern file: %s", line);
                        abort_run();
                    end else begin
                        imem[(a - RESET_PC) >> 2] = w;
                        prog_len++;
                    end
                end else if (line.len() > 1 && line[0] == "T") begin
                    n = $sscanf(line, "T %h %h %h", a, r, w);
                    if (n != 3) begin
                        $display("Error: bad trace line in pattern file: %s", line);
                        abort_run();
                    end else begin
                        exp_pc.push_back(a);
                        exp_reg.push_back(r);
                        exp_val.push_back(w);
                    end
                end
            end
            $fclose(fd);
        end
        trace_len = exp_val.size();
    endtask

    // --------------------
    // Clock and memories
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Both reads are combinational, so addresses settle right after the edge
    always @(posedge clk) begin
        #0.5;
        i_inst_rdata = fetch_word(i_inst_addr);
        m_data_rdata = dmem[m_data_addr[9:2]];
    end

    // Store commits at the coming edge, whole words only
    always @(negedge clk) begin
        if (arst_n && m_data_byteen !== 4'b0000 && m_data_byteen !== 4'b1111) begin
            $display("Error: byte enable %b is neither all ones nor zero", m_data_byteen);
            abort_run();
        end else if (arst_n && m_data_byteen == 4'b1111) begin
            dmem[m_data_addr[9:2]] = m_data_wdata;
        end
    end

    // --------------------
    // Trace checking
    always @(negedge clk) begin
        if (arst_n && w_grf_we && w_grf_addr != '0) begin
            if (trace_idx >= trace_len) begin
                $display("Error: register write to %0d after the expected trace ended",
                         w_grf_addr);
                abort_run();
            end else begin
                check_word("w_inst_addr", w_inst_addr, exp_pc[trace_idx]);
                check_reg("w_grf_addr", w_grf_addr, exp_reg[trace_idx]);
                check_word("w_grf_wdata", w_grf_wdata, exp_val[trace_idx]);
                trace_idx++;
            end
        end
    end

    initial begin
        wait (watchdog_cycles != 0);
        repeat (watchdog_cycles) @(posedge clk);
        $display("Error: write-back trace did not complete, %0d of %0d entries seen",
                 trace_idx, trace_len);
        abort_run();
    end

    // --------------------
    // Main sequence
    initial begin
        arst_n       = 1'b0;
        i_inst_rdata = '0;
        m_data_rdata = '0;
        prog_len     = 0;
        trace_len    = 0;
        trace_idx    = 0;
        void'($urandom(RAND_SEED));
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = '0;
        end
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = $urandom();
        end
        load_patterns();
        watchdog_cycles = (prog_len + trace_len) * 3;

        repeat (2) @(posedge clk);
        #0.5 arst_n = 1'b1;

        wait (trace_idx == trace_len);
        // A few more cycles to catch stray writes
        repeat (8) @(posedge clk);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire
